// File: flit_out_stage.sv
module flit_out_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_en,
    input  vc_buffer_pkg::vc_id_t rd_vc,
    input  vc_buffer_pkg::flit_t  rd_data,
    output logic                  out_valid,
    output vc_buffer_pkg::vc_id_t out_vc,
    output vc_buffer_pkg::flit_t  out_flit,
    output logic                  credit_valid,
    output vc_buffer_pkg::vc_id_t credit_vc
);

    logic                  rd_q;      // read whose word sits in the memory register
    vc_buffer_pkg::vc_id_t rd_vc_q;
    vc_buffer_pkg::vc_id_t vc_q;      // vc of the flit on the output
    vc_buffer_pkg::flit_t  flit_q;

    // valid and credit trail the memory read register by one stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_q         <= 1'b0;
            out_valid    <= 1'b0;
            credit_valid <= 1'b0;
        end else begin
            rd_q         <= rd_en;
            out_valid    <= rd_q;
            credit_valid <= rd_q;   // one credit back per flit read
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_vc_q <= rd_vc;
        end
        if (rd_q) begin
            vc_q   <= rd_vc_q;
            flit_q <= rd_data;
        end
    end

    assign out_vc    = vc_q;
    assign out_flit  = flit_q;
    assign credit_vc = vc_q;

    // a credit always travels with the flit it frees
    a_credit_with_flit: assert property (
        @(posedge clk) disable iff (reset)
        credit_valid |-> (out_valid && credit_vc == out_vc)
    ) else $error("credit for vc %0d without a valid flit", credit_vc);

endmodule

// File: flit_ram.sv
module flit_ram (
    input  logic                 clk,
    ram_port_if.ram              ram,
    input  vc_buffer_pkg::flit_t wr_data,
    output vc_buffer_pkg::flit_t rd_data
);

    localparam int WORDS = vc_buffer_pkg::NUM_VC * vc_buffer_pkg::VC_DEPTH;

    vc_buffer_pkg::flit_t mem [WORDS];
    vc_buffer_pkg::flit_t rd_q;   // registered read port

    always_ff @(posedge clk) begin
        if (ram.wr_en) begin
            mem[ram.wr_addr] <= wr_data;
        end
        // holds the last word read when rd_en is low
        if (ram.rd_en) begin
            rd_q <= mem[ram.rd_addr];
        end
    end

    assign rd_data = rd_q;

    // the pointer logic keeps a read off the slot being written,
    // so read-during-write behaviour of the memory never matters
    a_no_addr_clash: assert property (
        @(posedge clk)
        (ram.wr_en && ram.rd_en) |-> (ram.wr_addr != ram.rd_addr)
    ) else $error("read and write to the same slot %0h", ram.rd_addr);

endmodule

// File: ram_port_if.sv
interface ram_port_if;

    logic                    wr_en;
    vc_buffer_pkg::mem_addr_t wr_addr;
    logic                    rd_en;
    vc_buffer_pkg::mem_addr_t rd_addr;

    modport ctrl (
        output wr_en,
        output wr_addr,
        output rd_en,
        output rd_addr
    );

    modport ram (
        input wr_en,
        input wr_addr,
        input rd_en,
        input rd_addr
    );

endinterface

// File: src.f
vc_buffer_pkg.sv
ram_port_if.sv
vc_buffer_ctrl.sv
flit_ram.sv
flit_out_stage.sv
vc_input_buffer.sv
tb_vc_input_buffer.sv

// File: tb_vc_input_buffer.sv
module tb_vc_input_buffer;

    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_CYCLES = 400;
    // directed tests take about a hundred cycles, random drain a few more
    localparam int TEST_CYCLES   = RESET_CYCLES + 100 + RANDOM_CYCLES + 20;
    localparam int MARGIN_CYCLES = 200;

    logic                                clk;
    logic                                reset;
    logic                                in_valid;
    vc_buffer_pkg::vc_id_t               in_vc;
    logic                                in_head;
    logic                                in_tail;
    logic [vc_buffer_pkg::PAYLOAD_W-1:0] in_payload;
    logic                                rd_en;
    vc_buffer_pkg::vc_id_t               rd_vc;
    logic [vc_buffer_pkg::NUM_VC-1:0]    vc_not_empty;
    logic                                out_valid;
    vc_buffer_pkg::vc_id_t               out_vc;
    logic                                out_head;
    logic                                out_tail;
    logic [vc_buffer_pkg::PAYLOAD_W-1:0] out_payload;
    logic                                credit_valid;
    vc_buffer_pkg::vc_id_t               credit_vc;

    // upstream credit model and per-vc reference fifos
    int                   credits [vc_buffer_pkg::NUM_VC];
    vc_buffer_pkg::flit_t ref_q   [vc_buffer_pkg::NUM_VC][$];

    // read issued one cycle ago, due on the output now
    logic                  exp_valid;
    vc_buffer_pkg::vc_id_t exp_vc;
    vc_buffer_pkg::flit_t  exp_flit;

    int seed;

    vc_input_buffer dut (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_vc        (in_vc),
        .in_head      (in_head),
        .in_tail      (in_tail),
        .in_payload   (in_payload),
        .rd_en        (rd_en),
        .rd_vc        (rd_vc),
        .vc_not_empty (vc_not_empty),
        .out_valid    (out_valid),
        .out_vc       (out_vc),
        .out_head     (out_head),
        .out_tail     (out_tail),
        .out_payload  (out_payload),
        .credit_valid (credit_valid),
        .credit_vc    (credit_vc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic vc_buffer_pkg::flit_t make_flit(
        input logic                                head,
        input logic                                tail,
        input logic [vc_buffer_pkg::PAYLOAD_W-1:0] payload
    );
        vc_buffer_pkg::flit_t f;
        f.head    = head;
        f.tail    = tail;
        f.payload = payload;
        return f;
    endfunction

    // one clock cycle: drive, update the model, then check after the edge
    task automatic run_cycle(input logic wr, input vc_buffer_pkg::vc_id_t wvc,
                             input vc_buffer_pkg::flit_t f,
                             input logic rd, input vc_buffer_pkg::vc_id_t rvc);
        vc_buffer_pkg::flit_t             popped;
        logic [vc_buffer_pkg::NUM_VC-1:0] exp_ne;
        popped     = '0;
        in_valid   = wr;
        in_vc      = wvc;
        in_head    = f.head;
        in_tail    = f.tail;
        in_payload = f.payload;
        rd_en      = rd;
        rd_vc      = rvc;
        if (rd) begin
            popped = ref_q[rvc].pop_front();   // needs a flit stored before this cycle
        end
        if (wr) begin
            ref_q[wvc].push_back(f);
            credits[wvc]--;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        check(out_valid, exp_valid, "out_valid");
        check(credit_valid, exp_valid, "credit_valid");
        if (exp_valid) begin
            check(out_vc, exp_vc, "out_vc");
            check(credit_vc, exp_vc, "credit_vc");
            check(out_head, exp_flit.head, "out_head");
            check(out_tail, exp_flit.tail, "out_tail");
            check(out_payload, exp_flit.payload, "out_payload");
        end
        if (credit_valid) begin
            credits[credit_vc]++;   // upstream takes the credit back
        end
        exp_valid = rd;
        exp_vc    = rvc;
        exp_flit  = popped;
        for (int v = 0; v < vc_buffer_pkg::NUM_VC; v++) begin
            exp_ne[v] = (ref_q[v].size() != 0);
        end
        check(vc_not_empty, exp_ne, "vc_not_empty");
        in_valid = 1'b0;
        rd_en    = 1'b0;
    endtask

    task automatic write_flit(input vc_buffer_pkg::vc_id_t vc, input vc_buffer_pkg::flit_t f);
        run_cycle(1'b1, vc, f, 1'b0, '0);
    endtask

    task automatic issue_read(input vc_buffer_pkg::vc_id_t vc);
        run_cycle(1'b0, '0, '0, 1'b1, vc);
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic check_all_credits(input int expected, input string what);
        for (int v = 0; v < vc_buffer_pkg::NUM_VC; v++) begin
            check(credits[v], expected, what);
        end
    endtask

    task automatic check_reset_state();
        repeat (3) idle_cycle();   // outputs stay quiet
        check(vc_not_empty, '0, "vc_not_empty after reset");
    endtask

    task automatic single_flit();
        write_flit(2'd2, make_flit(1'b1, 1'b1, 32'hc0de_0002));
        check(vc_not_empty, 4'b0100, "only vc 2 flagged after write");
        issue_read(2'd2);
        check(vc_not_empty, '0, "vc 2 empty after read");
        check(credits[2], vc_buffer_pkg::VC_DEPTH - 1, "credit not back yet");
        idle_cycle();   // flit and credit checked here
        check(credits[2], vc_buffer_pkg::VC_DEPTH, "credit for vc 2 returned");
    endtask

    task automatic independent_fifos();
        int order [16] = '{3, 1, 0, 2, 1, 3, 2, 0, 0, 2, 3, 1, 2, 0, 1, 3};
        // interleaved fill, slot by slot over all vcs
        for (int slot = 0; slot < vc_buffer_pkg::VC_DEPTH; slot++) begin
            for (int v = 0; v < vc_buffer_pkg::NUM_VC; v++) begin
                write_flit(vc_buffer_pkg::vc_id_t'(v),
                           make_flit(slot == 0, slot == vc_buffer_pkg::VC_DEPTH - 1,
                                     {8'hf0, 8'(v), 8'(slot), 8'h5a}));
            end
        end
        check_all_credits(0, "credits exhausted after fill");
        check(vc_not_empty, 4'b1111, "all vcs flagged after fill");
        for (int i = 0; i < 16; i++) begin
            issue_read(vc_buffer_pkg::vc_id_t'(order[i]));
            if (i % 3 == 2) begin
                idle_cycle();
            end
        end
        idle_cycle();
        check_all_credits(vc_buffer_pkg::VC_DEPTH, "credits after drain");
    endtask

    task automatic back_to_back_reads();
        for (int i = 0; i < 8; i++) begin
            write_flit(vc_buffer_pkg::vc_id_t'(i % 4), make_flit(i < 4, i >= 4, 32'hb2b0_0000 + i));
        end
        for (int i = 0; i < 8; i++) begin
            issue_read(vc_buffer_pkg::vc_id_t'(i % 4));   // one in flight, next issued
        end
        idle_cycle();
        check_all_credits(vc_buffer_pkg::VC_DEPTH, "credits after back-to-back reads");
    endtask

    task automatic simultaneous_traffic();
        write_flit(2'd1, make_flit(1'b1, 1'b0, 32'h5100_000a));
        write_flit(2'd1, make_flit(1'b0, 1'b0, 32'h5100_000b));
        // same vc, count stays at two
        run_cycle(1'b1, 2'd1, make_flit(1'b0, 1'b1, 32'h5100_000c), 1'b1, 2'd1);
        check(vc_not_empty, 4'b0010, "only vc 1 after same-vc write and read");
        run_cycle(1'b1, 2'd0, make_flit(1'b1, 1'b1, 32'h5000_000d), 1'b1, 2'd1);
        check(vc_not_empty, 4'b0011, "vc 0 and vc 1 after mixed cycle");
        run_cycle(1'b1, 2'd3, make_flit(1'b1, 1'b1, 32'h5300_000e), 1'b1, 2'd0);
        check(vc_not_empty, 4'b1010, "vc 1 and vc 3 after mixed cycle");
        issue_read(2'd1);
        issue_read(2'd3);
        idle_cycle();
        check_all_credits(vc_buffer_pkg::VC_DEPTH, "credits after simultaneous traffic");
    endtask

    task automatic random_traffic();
        int                    r;
        logic                  wr;
        logic                  rd;
        vc_buffer_pkg::vc_id_t wvc;
        vc_buffer_pkg::vc_id_t rvc;
        vc_buffer_pkg::flit_t  f;
        repeat (RANDOM_CYCLES) begin
            r   = $random(seed);
            wvc = r[1:0];
            rvc = r[3:2];
            wr  = (r[5:4] != 2'b00) && (credits[wvc] > 0);   // only with a credit
            rd  = r[6] && (ref_q[rvc].size() != 0);
            f   = make_flit(r[7], r[8], $random(seed));
            run_cycle(wr, wvc, f, rd, rvc);
        end
        for (int v = 0; v < vc_buffer_pkg::NUM_VC; v++) begin
            while (ref_q[v].size() != 0) begin
                issue_read(vc_buffer_pkg::vc_id_t'(v));
            end
        end
        idle_cycle();
        check_all_credits(vc_buffer_pkg::VC_DEPTH, "credits after random traffic");
    endtask

    // watchdog
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed       = 32'h4278_b7cf;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_vc      = '0;
        in_head    = 1'b0;
        in_tail    = 1'b0;
        in_payload = '0;
        rd_en      = 1'b0;
        rd_vc      = '0;
        exp_valid  = 1'b0;
        exp_vc     = '0;
        exp_flit   = '0;
        for (int v = 0; v < vc_buffer_pkg::NUM_VC; v++) begin
            credits[v] = vc_buffer_pkg::VC_DEPTH;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        check_reset_state();
        single_flit();
        independent_fifos();
        back_to_back_reads();
        simultaneous_traffic();
        random_traffic();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: vc_buffer_ctrl.sv
module vc_buffer_ctrl (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wr_valid,
    input  vc_buffer_pkg::vc_id_t              wr_vc,
    input  logic                               rd_en,
    input  vc_buffer_pkg::vc_id_t              rd_vc,
    output logic [vc_buffer_pkg::NUM_VC-1:0]   vc_not_empty,
    ram_port_if.ctrl                           ram
);

    vc_buffer_pkg::ptr_t   wr_ptr [vc_buffer_pkg::NUM_VC];
    vc_buffer_pkg::ptr_t   rd_ptr [vc_buffer_pkg::NUM_VC];
    vc_buffer_pkg::depth_t depth  [vc_buffer_pkg::NUM_VC];

    logic [vc_buffer_pkg::NUM_VC-1:0] wr_hit;   // write targets this vc
    logic [vc_buffer_pkg::NUM_VC-1:0] rd_hit;   // read targets this vc

    // binary vc id to per-vc strobes
    always_comb begin
        for (int i = 0; i < vc_buffer_pkg::NUM_VC; i++) begin
            wr_hit[i] = wr_valid && (wr_vc == vc_buffer_pkg::vc_id_t'(i));
            rd_hit[i] = rd_en && (rd_vc == vc_buffer_pkg::vc_id_t'(i));
        end
    end

    // each vc is its own circular fifo over its slice
    for (genvar v = 0; v < vc_buffer_pkg::NUM_VC; v++) begin : g_vc
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                depth[v]  <= '0;
            end else begin
                if (wr_hit[v]) begin
                    wr_ptr[v] <= wr_ptr[v] + 1'b1;   // wraps at VC_DEPTH
                end
                if (rd_hit[v]) begin
                    rd_ptr[v] <= rd_ptr[v] + 1'b1;
                end
                // simultaneous write and read leaves the count alone
                if (wr_hit[v] && !rd_hit[v]) begin
                    depth[v] <= depth[v] + 1'b1;
                end else if (!wr_hit[v] && rd_hit[v]) begin
                    depth[v] <= depth[v] - 1'b1;
                end
            end
        end

        assign vc_not_empty[v] = (depth[v] != '0);
    end

    // slice base from vc id, offset from that vc's pointer
    assign ram.wr_en   = wr_valid;
    assign ram.wr_addr = {wr_vc, wr_ptr[wr_vc]};
    assign ram.rd_en   = rd_en;
    assign ram.rd_addr = {rd_vc, rd_ptr[rd_vc]};

    // upstream credit count must keep a full vc from being written
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        wr_valid |-> (depth[wr_vc] != vc_buffer_pkg::depth_t'(vc_buffer_pkg::VC_DEPTH))
    ) else $error("write to full vc %0d", wr_vc);

    // downstream may only pick a vc it sees as not empty
    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset)
        rd_en |-> vc_not_empty[rd_vc]
    ) else $error("read from empty vc %0d", rd_vc);

endmodule

// File: vc_buffer_pkg.sv
package vc_buffer_pkg;

    // buffer geometry
    localparam int NUM_VC    = 4;
    localparam int VC_DEPTH  = 4;   // flit slots per vc, power of two
    localparam int PAYLOAD_W = 32;

    // derived widths
    localparam int VC_W    = 2;
    localparam int PTR_W   = 2;
    localparam int DEPTH_W = PTR_W + 1;   // must reach VC_DEPTH
    localparam int ADDR_W  = VC_W + PTR_W;

    // binary vc number
    typedef logic [VC_W-1:0] vc_id_t;

    // slot index inside one vc slice, wraps on its own
    typedef logic [PTR_W-1:0] ptr_t;

    // occupancy of one vc
    typedef logic [DEPTH_W-1:0] depth_t;

    // memory address, vc id on top and slot below
    typedef logic [ADDR_W-1:0] mem_addr_t;

    // memory word, vc is not stored
    typedef struct packed {
        logic                 head;
        logic                 tail;
        logic [PAYLOAD_W-1:0] payload;
    } flit_t;

endpackage

// File: vc_input_buffer.sv
module vc_input_buffer (
    input  logic                                   clk,
    input  logic                                   reset,

    // upstream link
    input  logic                                   in_valid,
    input  vc_buffer_pkg::vc_id_t                  in_vc,
    input  logic                                   in_head,
    input  logic                                   in_tail,
    input  logic [vc_buffer_pkg::PAYLOAD_W-1:0]    in_payload,

    // downstream read request
    input  logic                                   rd_en,
    input  vc_buffer_pkg::vc_id_t                  rd_vc,

    output logic [vc_buffer_pkg::NUM_VC-1:0]       vc_not_empty,
    output logic                                   out_valid,
    output vc_buffer_pkg::vc_id_t                  out_vc,
    output logic                                   out_head,
    output logic                                   out_tail,
    output logic [vc_buffer_pkg::PAYLOAD_W-1:0]    out_payload,

    // credit return to upstream
    output logic                                   credit_valid,
    output vc_buffer_pkg::vc_id_t                  credit_vc
);

    vc_buffer_pkg::flit_t in_flit;
    vc_buffer_pkg::flit_t ram_rd_data;
    vc_buffer_pkg::flit_t out_flit;

    ram_port_if ram_port ();

    // only head, tail and payload go into memory
    assign in_flit.head    = in_head;
    assign in_flit.tail    = in_tail;
    assign in_flit.payload = in_payload;

    vc_buffer_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .wr_valid     (in_valid),
        .wr_vc        (in_vc),
        .rd_en        (rd_en),
        .rd_vc        (rd_vc),
        .vc_not_empty (vc_not_empty),
        .ram          (ram_port.ctrl)
    );

    flit_ram u_ram (
        .clk     (clk),
        .ram     (ram_port.ram),
        .wr_data (in_flit),
        .rd_data (ram_rd_data)
    );

    flit_out_stage u_out (
        .clk          (clk),
        .reset        (reset),
        .rd_en        (rd_en),
        .rd_vc        (rd_vc),
        .rd_data      (ram_rd_data),
        .out_valid    (out_valid),
        .out_vc       (out_vc),
        .out_flit     (out_flit),
        .credit_valid (credit_valid),
        .credit_vc    (credit_vc)
    );

    assign out_head    = out_flit.head;
    assign out_tail    = out_flit.tail;
    assign out_payload = out_flit.payload;

endmodule
